/* cpu_patterns.txt */
# I <imem word> <instr> | D <dmem word> <value> | E <test> <dmem word> <expected>
# All numbers hex, program starts at word 0
I 000 00003083 # ld   x1, 0(x0)
I 001 00803103 # ld   x2, 8(x0)
I 002 002081b3 # add  x3, x1, x2   load-use on x2
I 003 40208233 # sub  x4, x1, x2
I 004 0020f2b3 # and  x5, x1, x2
I 005 0020e333 # or   x6, x1, x2
I 006 08303023 # sd   x3, 128(x0)
I 007 08403423 # sd   x4, 136(x0)
I 008 08503823 # sd   x5, 144(x0)
I 009 08603c23 # sd   x6, 152(x0)
I 00a ffb00393 # addi x7, x0, -5
I 00b 80038413 # addi x8, x7, -2048
I 00c 06438013 # addi x0, x7, 100
I 00d 008004b3 # add  x9, x0, x8
I 00e 0a703023 # sd   x7, 160(x0)
I 00f 0a903423 # sd   x9, 168(x0)
I 010 3e800513 # addi x10, x0, 1000
I 011 00a505b3 # add  x11, x10, x10
I 012 40a58633 # sub  x12, x11, x10
I 013 00b666b3 # or   x13, x12, x11
I 014 0ad03823 # sd   x13, 176(x0)
I 015 01003703 # ld   x14, 16(x0)
I 016 001707b3 # add  x15, x14, x1  load-use on x14
I 017 0af03c23 # sd   x15, 184(x0)
I 018 10000893 # addi x17, x0, 256
I 019 0038b423 # sd   x3, 8(x17)
D 000 0123456789abcdef
D 001 0f0f0f0f0f0f0f0f
D 002 7fffffffffffffff
D 020 1111111111111111
D 021 2222222222222222
D 022 3333333333333333
E preload_w0 000 0123456789abcdef
E preload_w2 002 7fffffffffffffff
E r_add 010 1032547698badcfe
E r_sub 011 f21436587a9cbee0
E r_and 012 01030507090b0d0f
E r_or 013 0f2f4f6f8fafcfef
E addi_neg 014 fffffffffffffffb
E x0_zero 015 fffffffffffff7fb
E fwd_chain 016 00000000000007f8
E load_use 017 8123456789abcdee
E sd_below 020 1111111111111111
E sd_target 021 1032547698badcfe
E sd_above 022 3333333333333333

/* cpu.f */
riscv_pkg.sv
pipe_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu.sv
cpu_checker.sv
cpu_asserts.sv
tb_cpu.sv

/* tb_cpu.sv */
// CPU pipeline testbench

`timescale 1ns/1ps

module tb_cpu;

   localparam int fill_base  = 64;
   localparam int fill_words = 8;
   localparam int pad_words  = 16;
   localparam int run_extra  = 12;

   logic                              clk;
   logic                              rst;
   logic                              enable;
   logic [riscv_pkg::imem_addr_w-1:0] addr_ext;
   logic                              wen_ext;
   logic                              ren_ext;
   logic [riscv_pkg::instr_w-1:0]     wdata_ext;
   logic [riscv_pkg::instr_w-1:0]     rdata_ext;
   logic [riscv_pkg::dmem_addr_w-1:0] addr_ext_2;
   logic                              wen_ext_2;
   logic                              ren_ext_2;
   logic [riscv_pkg::xlen-1:0]        wdata_ext_2;
   logic [riscv_pkg::xlen-1:0]        rdata_ext_2;

   // Records from the pattern file
   int          i_addr [$];
   logic [31:0] i_data [$];
   int          d_addr [$];
   logic [63:0] d_data [$];
   int          e_addr [$];

   int seed;
   int cycle_count;
   int cycle_limit;
   int tb_errors;
   int checker_errors;
   int compare_count;
   int reads_issued;

   cpu u_cpu (
      .clk         (clk),
      .rst         (rst),
      .enable      (enable),
      .addr_ext    (addr_ext),
      .wen_ext     (wen_ext),
      .ren_ext     (ren_ext),
      .wdata_ext   (wdata_ext),
      .rdata_ext   (rdata_ext),
      .addr_ext_2  (addr_ext_2),
      .wen_ext_2   (wen_ext_2),
      .ren_ext_2   (ren_ext_2),
      .wdata_ext_2 (wdata_ext_2),
      .rdata_ext_2 (rdata_ext_2)
   );

   cpu_checker u_checker (
      .clk           (clk),
      .rst           (rst),
      .addr_ext      (addr_ext),
      .ren_ext       (ren_ext),
      .rdata_ext     (rdata_ext),
      .addr_ext_2    (addr_ext_2),
      .wen_ext_2     (wen_ext_2),
      .ren_ext_2     (ren_ext_2),
      .wdata_ext_2   (wdata_ext_2),
      .rdata_ext_2   (rdata_ext_2),
      .error_count   (checker_errors),
      .compare_count (compare_count)
   );

   always #10 clk = ~clk;

   // Run limit guard
   always @(posedge clk) begin
      if (cycle_count >= cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("SOME TESTS FAILED");
         $finish;
      end else begin
         cycle_count <= cycle_count + 1;
      end
   end

   task automatic read_patterns();
      int             fd;
      int             code;
      byte            kind;
      logic [255:0]   name;
      logic [31:0]    idx;
      logic [63:0]    value;
      logic [1023:0]  line;
      fd = $fopen("cpu_patterns.txt", "r");
      if (fd == 0) begin
         $display("Cannot open cpu_patterns.txt, no stimulus loaded");
         tb_errors++;
      end else begin
         while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code == 1) begin
               case (kind)
                  "I": begin
                     code = $fscanf(fd, "%h %h", idx, value);
                     i_addr.push_back(idx);
                     i_data.push_back(value[31:0]);
                  end
                  "D": begin
                     code = $fscanf(fd, "%h %h", idx, value);
                     d_addr.push_back(idx);
                     d_data.push_back(value);
                  end
                  "E": begin
                     code = $fscanf(fd, "%s %h %h", name, idx, value);
                     e_addr.push_back(idx);
                  end
                  // Comments and anything else run to end of line
                  default: code = $fgets(line, fd);
               endcase
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic write_imem(input int idx, input logic [31:0] data);
      @(posedge clk);
      wen_ext_2 <= 1'b0;
      addr_ext  <= idx;
      wdata_ext <= data;
      wen_ext   <= 1'b1;
   endtask

   task automatic write_dmem(input int idx, input logic [63:0] data);
      @(posedge clk);
      wen_ext     <= 1'b0;
      addr_ext_2  <= idx;
      wdata_ext_2 <= data;
      wen_ext_2   <= 1'b1;
   endtask

   task automatic read_imem(input int idx);
      @(posedge clk);
      ren_ext_2 <= 1'b0;
      addr_ext  <= idx;
      ren_ext   <= 1'b1;
      reads_issued++;
   endtask

   task automatic read_dmem(input int idx);
      @(posedge clk);
      ren_ext    <= 1'b0;
      addr_ext_2 <= idx;
      ren_ext_2  <= 1'b1;
      reads_issued++;
   endtask

   task automatic preload_memories();
      for (int k = 0; k < i_addr.size(); k++) begin
         write_imem(i_addr[k], i_data[k]);
      end
      // Zero words after the program decode as bubbles
      for (int k = 0; k < pad_words; k++) begin
         write_imem(i_addr.size() + k, '0);
      end
      for (int k = 0; k < d_addr.size(); k++) begin
         write_dmem(d_addr[k], d_data[k]);
      end
      // Words the program never touches
      for (int k = 0; k < fill_words; k++) begin
         write_dmem(fill_base + k, {$random(seed), $random(seed)});
      end
      @(posedge clk);
      wen_ext   <= 1'b0;
      wen_ext_2 <= 1'b0;
   endtask

   task automatic run_program();
      @(posedge clk);
      enable <= 1'b1;
      repeat (i_addr.size() + run_extra) @(posedge clk);
      enable <= 1'b0;
   endtask

   task automatic read_back();
      for (int k = 0; k < i_addr.size(); k++) begin
         read_imem(i_addr[k]);
      end
      for (int k = 0; k < e_addr.size(); k++) begin
         read_dmem(e_addr[k]);
      end
      for (int k = 0; k < fill_words; k++) begin
         read_dmem(fill_base + k);
      end
      @(posedge clk);
      ren_ext   <= 1'b0;
      ren_ext_2 <= 1'b0;
      wait (compare_count == reads_issued);
      repeat (2) @(posedge clk);
   endtask

   initial begin
      clk         = 1'b0;
      rst         = 1'b1;
      enable      = 1'b0;
      addr_ext    = '0;
      wen_ext     = 1'b0;
      ren_ext     = 1'b0;
      wdata_ext   = '0;
      addr_ext_2  = '0;
      wen_ext_2   = 1'b0;
      ren_ext_2   = 1'b0;
      wdata_ext_2 = '0;
      seed        = 32'h2608ccec;
      cycle_count = 0;
      tb_errors   = 0;
      reads_issued = 0;
      read_patterns();
      // Reset, preload, run and readback lengths plus margin
      cycle_limit = 8 + (i_addr.size() + pad_words + d_addr.size() + fill_words + 1)
                    + (i_addr.size() + run_extra + 1)
                    + (i_addr.size() + e_addr.size() + fill_words + 4) + 50;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      preload_memories();
      run_program();
      read_back();
      if (e_addr.size() == 0) begin
         $display("No expected data records found, nothing was checked");
         tb_errors++;
      end
      $display("Errors: checker %0d, assertions %0d, testbench %0d",
               checker_errors, u_cpu.u_asserts.assert_errors, tb_errors);
      if (checker_errors == 0 && u_cpu.u_asserts.assert_errors == 0 && tb_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* cpu_asserts.sv */
// Pipeline port and stall assertions

`timescale 1ns/1ps

module cpu_asserts (
   input logic                       clk,
   input logic                       rst,
   input logic                       enable,
   input logic                       wen_ext,
   input logic                       wen_ext_2,
   input logic                       ren_ext_2,
   input logic [riscv_pkg::xlen-1:0] rdata_ext_2,
   input logic                       stall
);

   int assert_errors = 0;

   // Memories are loaded only while the core is halted
   no_ext_write_running: assert property (@(posedge clk) disable iff (rst)
      enable |-> !wen_ext && !wen_ext_2)
   else begin
      assert_errors++;
      $error("External memory write while the core is running");
   end

   readback_known: assert property (@(posedge clk) disable iff (rst)
      ren_ext_2 |=> !$isunknown(rdata_ext_2))
   else begin
      assert_errors++;
      $error("Data readback unknown one cycle after the read");
   end

   // A bubble follows the load, so the hazard clears
   stall_one_cycle: assert property (@(posedge clk) disable iff (rst)
      enable && stall |=> !stall)
   else begin
      assert_errors++;
      $error("Load-use stall held for two cycles");
   end

endmodule

bind cpu cpu_asserts u_asserts (
   .clk         (clk),
   .rst         (rst),
   .enable      (enable),
   .wen_ext     (wen_ext),
   .wen_ext_2   (wen_ext_2),
   .ren_ext_2   (ren_ext_2),
   .rdata_ext_2 (rdata_ext_2),
   .stall       (stall)
);

/* cpu_checker.sv */
// External port readback checker

`timescale 1ns/1ps

module cpu_checker (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [riscv_pkg::imem_addr_w-1:0] addr_ext,
   input  logic                              ren_ext,
   input  riscv_pkg::instr_t                 rdata_ext,
   input  logic [riscv_pkg::dmem_addr_w-1:0] addr_ext_2,
   input  logic                              wen_ext_2,
   input  logic                              ren_ext_2,
   input  riscv_pkg::word_t                  wdata_ext_2,
   input  riscv_pkg::word_t                  rdata_ext_2,
   output int                                error_count,
   output int                                compare_count
);

   // Expected results by word index
   riscv_pkg::word_t  exp_value [int];
   logic [255:0]      exp_name [int];
   // Program words by instruction word index
   riscv_pkg::instr_t exp_instr [int];
   // Last value written through the external port
   riscv_pkg::word_t  shadow [int];
   logic              pending;
   int                pending_addr;
   logic              instr_pending;
   int                instr_pending_addr;

   initial begin : load_expected
      int            fd;
      int            code;
      byte           kind;
      logic [255:0]  name;
      logic [31:0]   idx;
      logic [63:0]   value;
      logic [1023:0] line;
      error_count        = 0;
      compare_count      = 0;
      pending            = 1'b0;
      pending_addr       = 0;
      instr_pending      = 1'b0;
      instr_pending_addr = 0;
      fd = $fopen("cpu_patterns.txt", "r");
      if (fd == 0) begin
         $display("Checker cannot open cpu_patterns.txt");
         error_count++;
      end else begin
         while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code == 1) begin
               if (kind == "E") begin
                  code = $fscanf(fd, "%s %h %h", name, idx, value);
                  exp_name[idx]  = name;
                  exp_value[idx] = value;
               end else if (kind == "I") begin
                  code = $fscanf(fd, "%h %h", idx, value);
                  exp_instr[idx] = value[riscv_pkg::instr_w-1:0];
               end else begin
                  code = $fgets(line, fd);
               end
            end
         end
         $fclose(fd);
      end
   end

   // Data arrives one cycle after the read request
   always @(posedge clk) begin : compare_readback
      riscv_pkg::word_t expected;
      logic [255:0]     name;
      if (rst) begin
         pending       = 1'b0;
         instr_pending = 1'b0;
      end else begin
         if (pending) begin
            compare_count++;
            if (exp_value.exists(pending_addr)) begin
               expected = exp_value[pending_addr];
               name     = exp_name[pending_addr];
            end else if (shadow.exists(pending_addr)) begin
               expected = shadow[pending_addr];
               name     = "preload_unchanged";
            end else begin
               expected = 'x;
               name     = "unknown";
               $display("Read of data word %0d, which has no expected value", pending_addr);
               error_count++;
            end
            if (rdata_ext_2 !== expected) begin
               $display("** Error %0s word %0d: expected %h, actual %h",
                        name, pending_addr, expected, rdata_ext_2);
               error_count++;
            end
         end
         if (instr_pending) begin
            compare_count++;
            if (!exp_instr.exists(instr_pending_addr)) begin
               $display("Read of instruction word %0d, which has no expected value",
                        instr_pending_addr);
               error_count++;
            end else if (rdata_ext !== exp_instr[instr_pending_addr]) begin
               $display("** Error imem_readback word %0d: expected %h, actual %h",
                        instr_pending_addr, exp_instr[instr_pending_addr], rdata_ext);
               error_count++;
            end
         end
         pending            = ren_ext_2;
         pending_addr       = addr_ext_2;
         instr_pending      = ren_ext;
         instr_pending_addr = addr_ext;
         if (wen_ext_2) begin
            shadow[addr_ext_2] = wdata_ext_2;
         end
      end
   end

endmodule

/* cpu.sv */
// Five-stage RV64 core

`timescale 1ns/1ps

module cpu (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              enable,
   input  logic [riscv_pkg::imem_addr_w-1:0] addr_ext,
   input  logic                              wen_ext,
   input  logic                              ren_ext,
   input  logic [riscv_pkg::instr_w-1:0]     wdata_ext,
   output logic [riscv_pkg::instr_w-1:0]     rdata_ext,
   input  logic [riscv_pkg::dmem_addr_w-1:0] addr_ext_2,
   input  logic                              wen_ext_2,
   input  logic                              ren_ext_2,
   input  logic [riscv_pkg::xlen-1:0]        wdata_ext_2,
   output logic [riscv_pkg::xlen-1:0]        rdata_ext_2
);

   riscv_pkg::instr_t    instr;
   logic                 stall;
   logic                 wb_reg_write;
   riscv_pkg::reg_addr_t wb_waddr;
   riscv_pkg::word_t     wb_wdata;

   id_ex_if  u_id_ex ();
   ex_mem_if u_ex_mem ();

   fetch_stage u_fetch (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .stall     (stall),
      .addr_ext  (addr_ext),
      .wen_ext   (wen_ext),
      .ren_ext   (ren_ext),
      .wdata_ext (wdata_ext),
      .rdata_ext (rdata_ext),
      .instr     (instr)
   );

   decode_stage u_decode (
      .clk          (clk),
      .rst          (rst),
      .enable       (enable),
      .instr        (instr),
      .wb_reg_write (wb_reg_write),
      .wb_waddr     (wb_waddr),
      .wb_wdata     (wb_wdata),
      .stall        (stall),
      .id_ex        (u_id_ex.src)
   );

   execute_stage u_execute (
      .clk          (clk),
      .rst          (rst),
      .enable       (enable),
      .id_ex        (u_id_ex.dst),
      .wb_reg_write (wb_reg_write),
      .wb_waddr     (wb_waddr),
      .wb_wdata     (wb_wdata),
      .ex_mem       (u_ex_mem.src)
   );

   memory_stage u_memory (
      .clk          (clk),
      .rst          (rst),
      .enable       (enable),
      .ex_mem       (u_ex_mem.dst),
      .addr_ext_2   (addr_ext_2),
      .wen_ext_2    (wen_ext_2),
      .ren_ext_2    (ren_ext_2),
      .wdata_ext_2  (wdata_ext_2),
      .rdata_ext_2  (rdata_ext_2),
      .wb_reg_write (wb_reg_write),
      .wb_waddr     (wb_waddr),
      .wb_wdata     (wb_wdata)
   );

endmodule

/* memory_stage.sv */
// Data memory and writeback

`timescale 1ns/1ps

module memory_stage (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              enable,
   ex_mem_if.dst                             ex_mem,
   input  logic [riscv_pkg::dmem_addr_w-1:0] addr_ext_2,
   input  logic                              wen_ext_2,
   input  logic                              ren_ext_2,
   input  riscv_pkg::word_t                  wdata_ext_2,
   output riscv_pkg::word_t                  rdata_ext_2,
   output logic                              wb_reg_write,
   output riscv_pkg::reg_addr_t              wb_waddr,
   output riscv_pkg::word_t                  wb_wdata
);

   riscv_pkg::word_t                  dmem [0:2**riscv_pkg::dmem_addr_w-1];
   logic [riscv_pkg::dmem_addr_w-1:0] dmem_idx;
   riscv_pkg::word_t                  load_data;
   riscv_pkg::word_t                  mem_wb_load;
   riscv_pkg::word_t                  mem_wb_alu;
   riscv_pkg::reg_addr_t              mem_wb_rd;
   logic                              mem_wb_mem_2_reg;
   logic                              mem_wb_reg_write;

   // Doubleword index from ALU result bits 12 to 3
   assign dmem_idx  = ex_mem.alu_out[riscv_pkg::dmem_addr_w+2:3];
   assign load_data = ex_mem.mem_read ? dmem[dmem_idx] : '0;

   // Pipeline store and external port share the array
   always_ff @(posedge clk) begin
      if (enable && ex_mem.mem_write) begin
         dmem[dmem_idx] <= ex_mem.store_data;
      end
      if (wen_ext_2) begin
         dmem[addr_ext_2] <= wdata_ext_2;
      end
      if (ren_ext_2) begin
         rdata_ext_2 <= dmem[addr_ext_2];
      end
   end

   // MEM/WB register
   always_ff @(posedge clk) begin
      if (rst) begin
         mem_wb_rd        <= '0;
         mem_wb_mem_2_reg <= 1'b0;
         mem_wb_reg_write <= 1'b0;
      end else if (enable) begin
         mem_wb_rd        <= ex_mem.rd;
         mem_wb_mem_2_reg <= ex_mem.mem_2_reg;
         mem_wb_reg_write <= ex_mem.reg_write;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         mem_wb_load <= load_data;
         mem_wb_alu  <= ex_mem.alu_out;
      end
   end

   assign wb_reg_write = mem_wb_reg_write;
   assign wb_waddr     = mem_wb_rd;
   assign wb_wdata     = mem_wb_mem_2_reg ? mem_wb_load : mem_wb_alu;

endmodule

/* execute_stage.sv */
// Execute stage with operand forwarding

`timescale 1ns/1ps

module execute_stage (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 enable,
   id_ex_if.dst                 id_ex,
   input  logic                 wb_reg_write,
   input  riscv_pkg::reg_addr_t wb_waddr,
   input  riscv_pkg::word_t     wb_wdata,
   ex_mem_if.src                ex_mem
);

   riscv_pkg::word_t operand_a;
   riscv_pkg::word_t fwd_b;
   riscv_pkg::word_t operand_b;
   riscv_pkg::word_t alu_res;

   // Newest producer wins, x0 is never forwarded
   function automatic riscv_pkg::word_t forward(input riscv_pkg::reg_addr_t src,
                                                input riscv_pkg::word_t     reg_val);
      riscv_pkg::word_t value;
      if (src != '0 && ex_mem.reg_write && ex_mem.rd == src) begin
         value = ex_mem.alu_out;
      end else if (src != '0 && wb_reg_write && wb_waddr == src) begin
         value = wb_wdata;
      end else begin
         value = reg_val;
      end
      return value;
   endfunction

   always_comb begin
      operand_a = forward(id_ex.rs1, id_ex.rdata_1);
      fwd_b     = forward(id_ex.rs2, id_ex.rdata_2);
   end

   // Immediate replaces B only after forwarding
   assign operand_b = id_ex.alu_src ? id_ex.imm : fwd_b;

   always_comb begin
      case (id_ex.alu_op)
         riscv_pkg::alu_sub: alu_res = operand_a - operand_b;
         riscv_pkg::alu_and: alu_res = operand_a & operand_b;
         riscv_pkg::alu_or:  alu_res = operand_a | operand_b;
         default:            alu_res = operand_a + operand_b;
      endcase
   end

   // EX/MEM register
   always_ff @(posedge clk) begin
      if (rst) begin
         ex_mem.rd        <= '0;
         ex_mem.mem_read  <= 1'b0;
         ex_mem.mem_write <= 1'b0;
         ex_mem.mem_2_reg <= 1'b0;
         ex_mem.reg_write <= 1'b0;
      end else if (enable) begin
         ex_mem.rd        <= id_ex.rd;
         ex_mem.mem_read  <= id_ex.mem_read;
         ex_mem.mem_write <= id_ex.mem_write;
         ex_mem.mem_2_reg <= id_ex.mem_2_reg;
         ex_mem.reg_write <= id_ex.reg_write;
      end
   end

   // Store data is the forwarded rs2
   always_ff @(posedge clk) begin
      if (enable) begin
         ex_mem.alu_out    <= alu_res;
         ex_mem.store_data <= fwd_b;
      end
   end

endmodule

/* decode_stage.sv */
// Instruction decode stage

`timescale 1ns/1ps

module decode_stage (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 enable,
   input  riscv_pkg::instr_t    instr,
   input  logic                 wb_reg_write,
   input  riscv_pkg::reg_addr_t wb_waddr,
   input  riscv_pkg::word_t     wb_wdata,
   output logic                 stall,
   id_ex_if.src                 id_ex
);

   riscv_pkg::word_t     rf [0:2**riscv_pkg::reg_addr_w-1];
   riscv_pkg::reg_addr_t rs1;
   riscv_pkg::reg_addr_t rs2;
   riscv_pkg::reg_addr_t rd;
   logic [2:0]           funct3;
   logic [6:0]           funct7;
   riscv_pkg::word_t     rdata_1;
   riscv_pkg::word_t     rdata_2;
   riscv_pkg::word_t     imm;
   riscv_pkg::alu_op_e   alu_op;
   logic                 alu_src;
   logic                 mem_read;
   logic                 mem_write;
   logic                 mem_2_reg;
   logic                 reg_write;
   logic                 uses_rs2;

   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   assign rd     = instr[11:7];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   // Register file, x0 stays zero
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 2**riscv_pkg::reg_addr_w; i++) begin
            rf[i] <= '0;
         end
      end else if (enable && wb_reg_write && wb_waddr != '0) begin
         rf[wb_waddr] <= wb_wdata;
      end
   end

   // Write-first read so writeback is visible in the same cycle
   assign rdata_1 = (wb_reg_write && wb_waddr == rs1 && rs1 != '0) ? wb_wdata : rf[rs1];
   assign rdata_2 = (wb_reg_write && wb_waddr == rs2 && rs2 != '0) ? wb_wdata : rf[rs2];

   // Stores split the immediate around rd
   assign imm = (instr[6:0] == riscv_pkg::op_store) ?
                {{(riscv_pkg::xlen-12){instr[31]}}, instr[31:25], instr[11:7]} :
                {{(riscv_pkg::xlen-12){instr[31]}}, instr[31:20]};

   // Control decode, anything unknown stays a bubble
   always_comb begin
      alu_op    = riscv_pkg::alu_add;
      alu_src   = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      mem_2_reg = 1'b0;
      reg_write = 1'b0;
      uses_rs2  = 1'b0;
      case (instr[6:0])
         riscv_pkg::op_reg: begin
            uses_rs2 = 1'b1;
            if (funct3 == riscv_pkg::f3_add_sub && funct7 == riscv_pkg::f7_base) begin
               reg_write = 1'b1;
            end else if (funct3 == riscv_pkg::f3_add_sub && funct7 == riscv_pkg::f7_sub) begin
               alu_op    = riscv_pkg::alu_sub;
               reg_write = 1'b1;
            end else if (funct3 == riscv_pkg::f3_and && funct7 == riscv_pkg::f7_base) begin
               alu_op    = riscv_pkg::alu_and;
               reg_write = 1'b1;
            end else if (funct3 == riscv_pkg::f3_or && funct7 == riscv_pkg::f7_base) begin
               alu_op    = riscv_pkg::alu_or;
               reg_write = 1'b1;
            end
         end
         riscv_pkg::op_imm: begin
            if (funct3 == riscv_pkg::f3_add_sub) begin
               alu_src   = 1'b1;
               reg_write = 1'b1;
            end
         end
         riscv_pkg::op_load: begin
            if (funct3 == riscv_pkg::f3_dword) begin
               alu_src   = 1'b1;
               mem_read  = 1'b1;
               mem_2_reg = 1'b1;
               reg_write = 1'b1;
            end
         end
         riscv_pkg::op_store: begin
            uses_rs2 = 1'b1;
            if (funct3 == riscv_pkg::f3_dword) begin
               alu_src   = 1'b1;
               mem_write = 1'b1;
            end
         end
         default: ;
      endcase
   end

   // Load in execute feeding this instruction
   assign stall = id_ex.mem_read && id_ex.rd != '0 &&
                  (id_ex.rd == rs1 || (uses_rs2 && id_ex.rd == rs2));

   // ID/EX register
   always_ff @(posedge clk) begin
      if (rst) begin
         id_ex.alu_op    <= riscv_pkg::alu_add;
         id_ex.alu_src   <= 1'b0;
         id_ex.mem_read  <= 1'b0;
         id_ex.mem_write <= 1'b0;
         id_ex.mem_2_reg <= 1'b0;
         id_ex.reg_write <= 1'b0;
         id_ex.rs1       <= '0;
         id_ex.rs2       <= '0;
         id_ex.rd        <= '0;
      end else if (enable) begin
         id_ex.alu_op    <= alu_op;
         id_ex.alu_src   <= alu_src;
         id_ex.mem_read  <= mem_read && !stall;
         id_ex.mem_write <= mem_write && !stall;
         id_ex.mem_2_reg <= mem_2_reg && !stall;
         id_ex.reg_write <= reg_write && !stall;
         id_ex.rs1       <= rs1;
         id_ex.rs2       <= rs2;
         id_ex.rd        <= rd;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         id_ex.rdata_1 <= rdata_1;
         id_ex.rdata_2 <= rdata_2;
         id_ex.imm     <= imm;
      end
   end

endmodule

/* fetch_stage.sv */
// Instruction fetch stage

`timescale 1ns/1ps

module fetch_stage (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              enable,
   input  logic                              stall,
   input  logic [riscv_pkg::imem_addr_w-1:0] addr_ext,
   input  logic                              wen_ext,
   input  logic                              ren_ext,
   input  riscv_pkg::instr_t                 wdata_ext,
   output riscv_pkg::instr_t                 rdata_ext,
   output riscv_pkg::instr_t                 instr
);

   // Byte address, only the bits that reach the memory index
   logic [riscv_pkg::imem_addr_w+1:0] pc;

   riscv_pkg::instr_t imem [0:2**riscv_pkg::imem_addr_w-1];
   riscv_pkg::instr_t fetch_word;

   // Word index is PC bits 10 to 2
   assign fetch_word = imem[pc[riscv_pkg::imem_addr_w+1:2]];

   // External load and readback port
   always_ff @(posedge clk) begin
      if (wen_ext) begin
         imem[addr_ext] <= wdata_ext;
      end
      if (ren_ext) begin
         rdata_ext <= imem[addr_ext];
      end
   end

   // PC steps by one word unless decode holds it
   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (enable && !stall) begin
         pc <= pc + 4;
      end
   end

   // IF/ID register, a zero word decodes as a bubble
   always_ff @(posedge clk) begin
      if (rst) begin
         instr <= '0;
      end else if (enable && !stall) begin
         instr <= fetch_word;
      end
   end

endmodule

/* pipe_if.sv */
// Pipeline register bundles

`timescale 1ns/1ps

// Decode to execute
interface id_ex_if;
   riscv_pkg::alu_op_e   alu_op;
   logic                 alu_src;
   logic                 mem_read;
   logic                 mem_write;
   logic                 mem_2_reg;
   logic                 reg_write;
   riscv_pkg::reg_addr_t rs1;
   riscv_pkg::reg_addr_t rs2;
   riscv_pkg::reg_addr_t rd;
   riscv_pkg::word_t     rdata_1;
   riscv_pkg::word_t     rdata_2;
   riscv_pkg::word_t     imm;

   modport src (output alu_op, alu_src, mem_read, mem_write, mem_2_reg, reg_write,
                output rs1, rs2, rd, rdata_1, rdata_2, imm);
   modport dst (input alu_op, alu_src, mem_read, mem_write, mem_2_reg, reg_write,
                input rs1, rs2, rd, rdata_1, rdata_2, imm);
endinterface

// Execute to memory
interface ex_mem_if;
   riscv_pkg::word_t     alu_out;
   riscv_pkg::word_t     store_data;
   riscv_pkg::reg_addr_t rd;
   logic                 mem_read;
   logic                 mem_write;
   logic                 mem_2_reg;
   logic                 reg_write;

   modport src (output alu_out, store_data, rd, mem_read, mem_write, mem_2_reg, reg_write);
   modport dst (input alu_out, store_data, rd, mem_read, mem_write, mem_2_reg, reg_write);
endinterface

/* riscv_pkg.sv */
// RV64 pipeline shared definitions

package riscv_pkg;

   // Datapath and storage widths
   localparam int xlen        = 64;
   localparam int instr_w     = 32;
   localparam int reg_addr_w  = 5;
   localparam int imem_addr_w = 9;
   localparam int dmem_addr_w = 10;

   // funct3 and funct7 fields of the kept instructions
   localparam logic [2:0] f3_add_sub = 3'b000;
   localparam logic [2:0] f3_or      = 3'b110;
   localparam logic [2:0] f3_and     = 3'b111;
   localparam logic [2:0] f3_dword   = 3'b011;
   localparam logic [6:0] f7_base    = 7'b0000000;
   localparam logic [6:0] f7_sub     = 7'b0100000;

   typedef logic [xlen-1:0]       word_t;
   typedef logic [instr_w-1:0]    instr_t;
   typedef logic [reg_addr_w-1:0] reg_addr_t;

   // Major opcodes, standard RV encodings
   typedef enum logic [6:0] {
      op_reg   = 7'b0110011,
      op_imm   = 7'b0010011,
      op_load  = 7'b0000011,
      op_store = 7'b0100011
   } opcode_e;

   // Operations the execute stage knows
   typedef enum logic [1:0] {
      alu_add = 2'b00,
      alu_sub = 2'b01,
      alu_and = 2'b10,
      alu_or  = 2'b11
   } alu_op_e;

endpackage
